// ==== sim/vga_testdata.txt ====
// frame mode_sel col line vga_rgb vga_hsync vga_vsync, all hex
// mode_sel 0 image, 1 colour bars; every row of a frame gives the same mode
0 0 0 0 00 0 0
0 0 7F 3 00 0 0
0 0 80 4 00 1 1
0 0 D7 1B 00 1 1
0 0 D8 1B 00 1 1
0 0 E2 1B 01 1 1
0 0 3F7 1B 4D 1 1
0 0 D8 25 52 1 1
0 0 1F4 12C C8 1 1
0 0 3F7 272 2A 1 1
0 0 3F8 272 00 1 1
0 0 258 273 00 1 1
1 1 0 0 00 0 0
1 1 D8 1B 00 1 1
1 1 13B 1B 00 1 1
1 1 13C 64 03 1 1
1 1 1A0 C8 1C 1 1
1 1 204 12C 1F 1 1
1 1 268 190 E0 1 1
1 1 2CC 1F4 E3 1 1
1 1 330 258 FC 1 1
1 1 394 272 FF 1 1
1 1 3F7 272 FF 1 1
1 1 3F8 12C 00 1 1
1 1 64 12C 00 0 1
2 0 D8 1B 00 1 1
2 0 3F7 272 2A 1 1
2 0 1F4 12C C8 1 1
2 0 32 2 00 0 0
2 0 12C 3 00 1 0
2 0 E2 1B 01 1 1
2 0 D8 25 52 1 1
2 0 3F7 1B 4D 1 1
2 0 EC 2F A7 1 1
2 0 D8 272 E3 1 1

// ==== build.f ====
+incdir+common
common/vga_pkg.sv
vga/scan_timer.sv
vga/mode_fsm.sv
vga/pixel_addr.sv
vga/pixel_mux.sv
logic/vga_display_top.sv
sim/tb_clk_gen.sv
sim/tb_vga_display.sv

// ==== Makefile ====
# Verilator build and run of the VGA display testbench

SRCS := $(filter-out +incdir+%,$(shell cat build.f)) common/vga_consts.svh

.PHONY: run clean

run: obj_dir/Vtb_vga_display
	./obj_dir/Vtb_vga_display | tee sim.log
	grep -q "Regression passed" sim.log

obj_dir/Vtb_vga_display: build.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_vga_display -f build.f

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_vga_display.sv ====
// VGA display testbench
`timescale 1ns/1ps
`include "vga_consts.svh"

module tb_vga_display;
    import vga_pkg::*;

    localparam int NUM_FRAMES     = 3;
    localparam int MAX_ROWS       = 64;                              // probe rows the file may hold
    localparam int FRAME_CYCLES   = `VGA_H_TOTAL * `VGA_V_TOTAL;     // 663168
    localparam int TIMEOUT_CYCLES = 2_000_000;  // 3 frames is 1989504, plus reset and margin

    logic        vga_clk;
    logic        sys_rst_n;
    logic        mode_sel = 1'b0;
    rgb332_t     rom_data = '0;
    logic [12:0] rom_addr;
    rgb332_t     vga_rgb;
    logic        vga_hsync;
    logic        vga_vsync;

    logic [15:0] td [0:MAX_ROWS*7-1];       // raw file words, 7 per row
    int          n_rows;
    int          probe_frame [0:MAX_ROWS-1];
    int          probe_col   [0:MAX_ROWS-1];
    int          probe_line  [0:MAX_ROWS-1];
    logic [7:0]  probe_rgb   [0:MAX_ROWS-1];
    logic        probe_hs    [0:MAX_ROWS-1];
    logic        probe_vs    [0:MAX_ROWS-1];
    logic        mode_for_frame [0:NUM_FRAMES-1];  // 1 = bars

    tb_clk_gen i_clk_gen (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n)
    );

    vga_display_top i_vga_display_top (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .mode_sel  (mode_sel),
        .rom_data  (rom_data),
        .rom_addr  (rom_addr),
        .vga_rgb   (vga_rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

    // image rom contents, a pattern of the whole address
    function automatic logic [7:0] rom_byte(int addr);
        return 8'(addr ^ (addr >> 5));
    endfunction

    // synchronous rom model, data one clock after the address
    always @(posedge vga_clk) begin
        rom_data.raw <= rom_byte(int'(rom_addr));
    end

    // colour at a raster position from the pixel rules
    function automatic logic [7:0] expected_rgb(int col, int line, logic bars);
        rgb332_t px;
        int      bar;
        int      addr;
        px.raw = 8'h00;                         // black outside the window
        if (col >= `VGA_H_START && col < `VGA_H_END &&
            line >= `VGA_V_START && line < `VGA_V_END) begin
            if (bars) begin
                bar = (col - `VGA_H_START) / 100;
                px.fields.red   = bar[2] ? 3'd7 : 3'd0;
                px.fields.green = bar[1] ? 3'd7 : 3'd0;
                px.fields.blue  = bar[0] ? 2'd3 : 2'd0;
            end else begin
                addr = (col - `VGA_H_START) / `IMG_SCALE +
                       ((line - `VGA_V_START) / `IMG_SCALE) * `IMG_W;
                px.raw = rom_byte(addr);
            end
        end
        return px.raw;
    endfunction

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_pins(logic [7:0] exp_rgb, logic exp_hs, logic exp_vs,
                              int col, int line, int frame);
        assert (vga_rgb.raw === exp_rgb) else begin
            $display("ERROR vga_rgb got 0x%02h expected 0x%02h at col %0d line %0d frame %0d",
                     vga_rgb.raw, exp_rgb, col, line, frame);
            stop_with_failure();
        end
        assert (vga_hsync === exp_hs) else begin
            $display("ERROR vga_hsync got 0x%0h expected 0x%0h at col %0d line %0d frame %0d",
                     vga_hsync, exp_hs, col, line, frame);
            stop_with_failure();
        end
        assert (vga_vsync === exp_vs) else begin
            $display("ERROR vga_vsync got 0x%0h expected 0x%0h at col %0d line %0d frame %0d",
                     vga_vsync, exp_vs, col, line, frame);
            stop_with_failure();
        end
    endtask

    // probe rows and per-frame mode from the data file
    task automatic load_testdata();
        int   r;
        int   f;
        logic seen [0:NUM_FRAMES-1];
        for (r = 0; r < MAX_ROWS * 7; r++) begin
            td[r] = 16'hffff;                   // end marker
        end
        $readmemh("sim/vga_testdata.txt", td);
        n_rows = 0;
        while (n_rows < MAX_ROWS && td[n_rows*7] != 16'hffff) begin
            n_rows++;
        end
        for (f = 0; f < NUM_FRAMES; f++) begin
            seen[f] = 1'b0;
        end
        for (r = 0; r < n_rows; r++) begin
            probe_frame[r] = int'(td[r*7]);
            probe_col[r]   = int'(td[r*7+2]);
            probe_line[r]  = int'(td[r*7+3]);
            probe_rgb[r]   = td[r*7+4][7:0];
            probe_hs[r]    = td[r*7+5][0];
            probe_vs[r]    = td[r*7+6][0];
            f = probe_frame[r];
            if (f >= NUM_FRAMES) begin
                $display("test data row %0d names frame %0d, beyond the run", r, f);
                stop_with_failure();
            end
            if (!seen[f]) begin
                mode_for_frame[f] = td[r*7+1][0];
                seen[f] = 1'b1;
            end else if (mode_for_frame[f] != td[r*7+1][0]) begin
                $display("test data row %0d gives a second mode for frame %0d", r, f);
                stop_with_failure();
            end
        end
        for (f = 0; f < NUM_FRAMES; f++) begin
            if (!seen[f]) begin
                $display("test data has no rows for frame %0d", f);
                stop_with_failure();
            end
        end
    endtask

    // mode_sel changes once per frame, in top blanking of the frame before
    initial begin : stimulus
        int e;
        int target;
        void'($urandom(37));
        load_testdata();
        mode_sel = mode_for_frame[0];           // must be there for the first frame start
        @(posedge sys_rst_n);
        e = 0;                                  // edges since release
        for (int n = 1; n < NUM_FRAMES; n++) begin
            target = (n - 1) * FRAME_CYCLES
                     + (1 + int'($urandom % 26)) * `VGA_H_TOTAL
                     + int'($urandom % `VGA_H_TOTAL);
            while (e < target) begin
                @(posedge vga_clk);
                e++;
            end
            mode_sel <= mode_for_frame[n];      // after this frame's sample, before the next
        end
    end

    // pins sampled mid cycle, against a reference raster 3 clocks behind
    initial begin : raster_check
        int         t;
        int         ref_col;
        int         ref_line;
        int         ref_frame;
        int         probes_hit;
        logic [7:0] exp_rgb;
        t          = 0;
        ref_col    = 0;
        ref_line   = 0;
        ref_frame  = 0;
        probes_hit = 0;
        @(posedge sys_rst_n);
        while (ref_frame < NUM_FRAMES) begin
            @(negedge vga_clk);
            assert (rom_addr < 13'(`IMG_WORDS)) else begin
                $display("ERROR rom_addr got 0x%04h limit 0x%04h", rom_addr, 13'(`IMG_WORDS));
                stop_with_failure();
            end
            if (t < `VGA_PIPE) begin
                check_pins(8'h00, 1'b0, 1'b0, -1, -1, -1);  // still reset values
                t++;
            end else begin
                exp_rgb = expected_rgb(ref_col, ref_line, mode_for_frame[ref_frame]);
                check_pins(exp_rgb, ref_col >= `VGA_H_SYNC, ref_line >= `VGA_V_SYNC,
                           ref_col, ref_line, ref_frame);
                for (int r = 0; r < n_rows; r++) begin
                    if (probe_frame[r] == ref_frame && probe_col[r] == ref_col &&
                        probe_line[r] == ref_line) begin
                        check_pins(probe_rgb[r], probe_hs[r], probe_vs[r],
                                   ref_col, ref_line, ref_frame);
                        probes_hit++;
                    end
                end
                if (ref_col == `VGA_H_TOTAL - 1) begin
                    ref_col = 0;
                    if (ref_line == `VGA_V_TOTAL - 1) begin
                        ref_line = 0;
                        ref_frame++;
                    end else begin
                        ref_line++;
                    end
                end else begin
                    ref_col++;
                end
            end
        end
        if (probes_hit == n_rows) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("only %0d of %0d probe points were reached", probes_hit, n_rows);
            stop_with_failure();
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge vga_clk);
            cycles++;
        end
        $display("timeout, the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
        stop_with_failure();
    end

endmodule

// ==== sim/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
    output logic vga_clk,
    output logic sys_rst_n
);

    // 100 ns period
    initial begin
        vga_clk = 1'b0;
        forever begin
            #50 vga_clk = ~vga_clk;
        end
    end

    // held low for 10 clocks, released on an edge
    initial begin
        sys_rst_n = 1'b0;
        repeat (10) @(posedge vga_clk);
        sys_rst_n <= 1'b1;
    end

endmodule

// ==== logic/vga_display_top.sv ====
// VGA display top level
`timescale 1ns/1ps

module vga_display_top (
    input  logic             vga_clk,
    input  logic             sys_rst_n,
    input  logic             mode_sel,   // 0 image, 1 colour bars
    input  vga_pkg::rgb332_t rom_data,   // one cycle after rom_addr
    output logic [12:0]      rom_addr,
    output vga_pkg::rgb332_t vga_rgb,
    output logic             vga_hsync,
    output logic             vga_vsync
);
    import vga_pkg::*;

    scan_pos_t  pos;            // raster position
    logic       active;         // visible window
    logic       hsync_raw;      // undelayed syncs
    logic       vsync_raw;
    logic       frame_start;    // col 0, line 0
    disp_mode_e disp_mode;      // held for a whole frame

    scan_timer i_scan_timer (
        .vga_clk     (vga_clk),
        .sys_rst_n   (sys_rst_n),
        .pos         (pos),
        .active      (active),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .frame_start (frame_start)
    );

    mode_fsm i_mode_fsm (
        .vga_clk     (vga_clk),
        .sys_rst_n   (sys_rst_n),
        .frame_start (frame_start),
        .mode_sel    (mode_sel),
        .disp_mode   (disp_mode)
    );

    // address stage, drives the rom port directly
    pixel_addr i_pixel_addr (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .pos       (pos),
        .active    (active),
        .rom_addr  (rom_addr)
    );

    pixel_mux i_pixel_mux (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .rom_data  (rom_data),
        .pos       (pos),
        .active    (active),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .disp_mode (disp_mode),
        .vga_rgb   (vga_rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

endmodule

// ==== vga/pixel_mux.sv ====
// Pixel select and output pipeline
`timescale 1ns/1ps
`include "vga_consts.svh"

module pixel_mux (
    input  logic                vga_clk,
    input  logic                sys_rst_n,
    input  vga_pkg::rgb332_t    rom_data,
    input  vga_pkg::scan_pos_t  pos,
    input  logic                active,
    input  logic                hsync_raw,
    input  logic                vsync_raw,
    input  vga_pkg::disp_mode_e disp_mode,
    output vga_pkg::rgb332_t    vga_rgb,
    output logic                vga_hsync,
    output logic                vga_vsync
);
    import vga_pkg::*;

    // everything that must line up with the rom data
    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       active;
        logic [2:0] bar;
        disp_mode_e mode;
    } pix_ctl_t;

    pix_ctl_t   ctl_now;
    pix_ctl_t   ctl_s1;     // matches rom_addr
    pix_ctl_t   ctl_s2;     // matches rom_data
    logic [2:0] bar_idx;
    rgb332_t    bar_px;
    rgb332_t    pix_next;

    // bar index by threshold compare, no divide by 100
    always_comb begin
        bar_idx = 3'd0;
        for (int i = 1; i < 8; i++) begin
            if (pos.col >= 11'(`VGA_H_START + i * `VGA_BAR_W)) begin
                bar_idx = 3'(i);
            end
        end
    end

    assign ctl_now = '{hsync: hsync_raw, vsync: vsync_raw, active: active,
                       bar: bar_idx, mode: disp_mode};

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ctl_s1 <= '0;
            ctl_s2 <= '0;
        end else begin
            ctl_s1 <= ctl_now;
            ctl_s2 <= ctl_s1;
        end
    end

    // index bits pick full red, green, blue
    always_comb begin
        bar_px.fields.red   = ctl_s2.bar[2] ? 3'd7 : 3'd0;
        bar_px.fields.green = ctl_s2.bar[1] ? 3'd7 : 3'd0;
        bar_px.fields.blue  = ctl_s2.bar[0] ? 2'd3 : 2'd0;
    end

    always_comb begin
        pix_next.raw = 8'd0;                        // black in blanking
        if (ctl_s2.active) begin
            case (ctl_s2.mode)
                MODE_IMAGE: pix_next.raw = rom_data.raw;
                MODE_BARS:  pix_next = bar_px;
                default:    pix_next.raw = 8'd0;    // blank before first frame
            endcase
        end
    end

    // pins, third stage after the counters
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vga_rgb   <= '0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
        end else begin
            vga_rgb   <= pix_next;
            vga_hsync <= ctl_s2.hsync;
            vga_vsync <= ctl_s2.vsync;
        end
    end

endmodule

// ==== vga/pixel_addr.sv ====
// Image ROM address generator
`timescale 1ns/1ps
`include "vga_consts.svh"

module pixel_addr (
    input  logic               vga_clk,
    input  logic               sys_rst_n,
    input  vga_pkg::scan_pos_t pos,
    input  logic               active,
    output logic [12:0]        rom_addr
);

    logic [3:0]  sub_x;     // screen column within one image pixel, 0..9
    logic [6:0]  img_x;     // image column
    logic [3:0]  sub_y;     // screen line within one image row, 0..9
    logic [12:0] row_base;  // img_y * 80, stepped instead of multiplied
    logic [12:0] addr_now;  // address for the current position
    logic        line_last; // last visible column of a line
    logic        frame_top; // first cycle of a frame

    assign line_last = active && (pos.col == 11'(`VGA_H_END - 1));
    assign frame_top = (pos.col == 11'd0) && (pos.line == 10'd0);

    // horizontal magnify, restarts at every line since blanking precedes it
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sub_x <= 4'd0;
            img_x <= 7'd0;
        end else if (!active) begin
            sub_x <= 4'd0;
            img_x <= 7'd0;
        end else if (sub_x == 4'(`IMG_SCALE - 1)) begin
            sub_x <= 4'd0;
            img_x <= img_x + 7'd1;      // next image column
        end else begin
            sub_x <= sub_x + 4'd1;
        end
    end

    // vertical magnify, steps at the end of each visible line
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sub_y    <= 4'd0;
            row_base <= 13'd0;
        end else if (frame_top) begin
            sub_y    <= 4'd0;
            row_base <= 13'd0;
        end else if (line_last) begin
            if (sub_y == 4'(`IMG_SCALE - 1)) begin
                sub_y    <= 4'd0;
                row_base <= row_base + 13'(`IMG_W);  // next image row
            end else begin
                sub_y <= sub_y + 4'd1;
            end
        end
    end

    assign addr_now = row_base + 13'(img_x);

    // one cycle behind the position, parked at 0 in blanking
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rom_addr <= 13'd0;
        end else begin
            rom_addr <= active ? addr_now : 13'd0;
        end
    end

    a_addr_in_image : assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        active |=> (rom_addr < 13'(`IMG_WORDS))
    ) else $error("rom address %0d beyond image", rom_addr);

endmodule

// ==== vga/mode_fsm.sv ====
// Display mode FSM
`timescale 1ns/1ps

module mode_fsm (
    input  logic                vga_clk,
    input  logic                sys_rst_n,
    input  logic                frame_start,
    input  logic                mode_sel,   // 0 image, 1 colour bars
    output vga_pkg::disp_mode_e disp_mode
);
    import vga_pkg::*;

    typedef enum logic [1:0] {
        WAIT_FRAME = 2'd0,  // blank until the first frame begins
        IMAGE      = 2'd1,
        BARS       = 2'd2
    } fsm_state_e;

    fsm_state_e state;
    fsm_state_e state_nxt;

    // mode only moves at a frame boundary, so no frame tears
    always_comb begin
        state_nxt = state;
        if (frame_start) begin
            state_nxt = mode_sel ? BARS : IMAGE;  // sample selector once per frame
        end
    end

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= WAIT_FRAME;
        end else begin
            state <= state_nxt;
        end
    end

    // state to mode, one cycle after frame_start
    always_comb begin
        case (state)
            IMAGE:   disp_mode = MODE_IMAGE;
            BARS:    disp_mode = MODE_BARS;
            default: disp_mode = MODE_BLANK;  // waiting for first frame
        endcase
    end

    // any state change must follow a frame start
    a_change_on_frame : assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        !$stable(state) |-> $past(frame_start)
    ) else $error("display mode changed in mid frame");

endmodule

// ==== vga/scan_timer.sv ====
// VGA scan timer
`timescale 1ns/1ps
`include "vga_consts.svh"

module scan_timer (
    input  logic               vga_clk,
    input  logic               sys_rst_n,
    output vga_pkg::scan_pos_t pos,
    output logic               active,
    output logic               hsync_raw,
    output logic               vsync_raw,
    output logic               frame_start
);
    import vga_pkg::*;

    scan_pos_t cnt;         // current raster position
    logic      col_wrap;    // last column of a line
    logic      line_wrap;   // last line of a frame

    assign col_wrap  = (cnt.col == 11'(`VGA_H_TOTAL - 1));
    assign line_wrap = (cnt.line == 10'(`VGA_V_TOTAL - 1));

    // column counter, 0..1055
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt.col <= 11'd0;
        end else if (col_wrap) begin
            cnt.col <= 11'd0;
        end else begin
            cnt.col <= cnt.col + 11'd1;
        end
    end

    // line counter steps once per line
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt.line <= 10'd0;
        end else if (col_wrap) begin
            if (line_wrap) begin
                cnt.line <= 10'd0;          // back to top of frame
            end else begin
                cnt.line <= cnt.line + 10'd1;
            end
        end
    end

    assign pos = cnt;

    // sync pulses are active low at the start of each line / frame
    assign hsync_raw = (cnt.col >= 11'(`VGA_H_SYNC));
    assign vsync_raw = (cnt.line >= 10'(`VGA_V_SYNC));

    // visible 800x600 window
    assign active = (cnt.col >= 11'(`VGA_H_START)) && (cnt.col < 11'(`VGA_H_END)) &&
                    (cnt.line >= 10'(`VGA_V_START)) && (cnt.line < 10'(`VGA_V_END));

    assign frame_start = (cnt.col == 11'd0) && (cnt.line == 10'd0);  // one cycle per frame

    // both counters stay inside the raster
    a_pos_in_raster : assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        (cnt.col <= 11'(`VGA_H_TOTAL - 1)) && (cnt.line <= 10'(`VGA_V_TOTAL - 1))
    ) else $error("scan position out of raster: col %0d line %0d", cnt.col, cnt.line);

endmodule

// ==== common/vga_pkg.sv ====
// VGA display types
package vga_pkg;

    // rgb332 colour fields, msb first
    typedef struct packed {
        logic [2:0] red;    // 0..7
        logic [2:0] green;  // 0..7
        logic [1:0] blue;   // 0..3
    } rgb332_fields_t;

    // one pixel byte
    // rom data arrives as a raw byte, the bar generator fills the fields
    typedef union packed {
        logic [7:0]     raw;
        rgb332_fields_t fields;
    } rgb332_t;

    // raster position as held by the counters
    typedef struct packed {
        logic [10:0] col;   // 0..1055
        logic [9:0]  line;  // 0..627
    } scan_pos_t;

    // what the active region shows in the current frame
    typedef enum logic [1:0] {
        MODE_BLANK = 2'd0,  // before the first frame start
        MODE_IMAGE = 2'd1,  // magnified rom image
        MODE_BARS  = 2'd2   // eight vertical bars
    } disp_mode_e;

endpackage

// ==== common/vga_consts.svh ====
// VGA timing and image geometry
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// 800x600 at 60 Hz, 40 MHz pixel clock
// columns: 128 sync + 88 back porch + 800 visible + 40 front porch
`define VGA_H_TOTAL   (1056)
`define VGA_H_SYNC    (128)   // hsync low width
`define VGA_H_START   (216)   // first visible column
`define VGA_H_END     (1016)  // one past last visible column

// lines: 4 sync + 23 back porch + 600 visible + 1 front porch
`define VGA_V_TOTAL   (628)
`define VGA_V_SYNC    (4)     // vsync low width
`define VGA_V_START   (27)    // first visible line
`define VGA_V_END     (627)   // one past last visible line

// source image held in the external rom
`define IMG_W         (80)
`define IMG_H         (60)
`define IMG_SCALE     (10)    // each image pixel covers 10x10 screen pixels
`define IMG_WORDS     (`IMG_W * `IMG_H)

// colour bar width, 800 / 8
`define VGA_BAR_W     (100)

// counters to pins: address reg, rom read, output reg
`define VGA_PIPE      (3)

`endif
